// File: Makefile
VERILATOR ?= verilator
TOP ?= rw_manager_di_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rw_manager_di_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_di_assertions (
	input wire logic clock,
	input wire logic rst,
	input wire logic [$clog2(`RW_DI_OUT_CREDITS + 1)-1:0] credits,
	input rw_manager_pkg::buf_rd_t rd [`RW_DI_NUM_GROUPS],
	input wire logic [`RW_DI_NUM_GROUPS-1:0] word_free,
	input rw_manager_pkg::out_beat_t out
);

	logic [`RW_DI_NUM_GROUPS-1:0] rden;

	always_comb begin
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			rden[g] = rd[g].rden;
		end
	end

	// the engine never holds more beat slots than downstream granted at reset
	credit_bound: assert property (@(posedge clock) disable iff (rst)
		credits <= `RW_DI_OUT_CREDITS)
		else $error("output credit count rose above its initial value");

	// every read carries a reserved beat slot
	read_has_credit: assert property (@(posedge clock) disable iff (rst)
		(|rden) |-> (credits != '0))
		else $error("read issued with no output credit");

	// one reader per cycle, which keeps the OR of the responses clean
	single_read: assert property (@(posedge clock) disable iff (rst)
		$onehot0(rden))
		else $error("more than one group read in the same cycle");

	// once reset has been held over an edge everything stays quiet
	quiet_in_reset: assert property (@(posedge clock)
		rst && $past(rst) |-> !(|rden) && !out.valid && !(|word_free))
		else $error("valid, rden or word_free active during reset");

endmodule

bind rw_manager_readback rw_manager_di_assertions u_di_assertions (
	.clock(clock),
	.rst(rst),
	.credits(credits),
	.rd(rd),
	.word_free(word_free),
	.out(out)
);

`default_nettype wire

// File: bench/rw_manager_di_stim.txt
# columns: group, 36-bit captured word, expected slices 0 to 3 (all hex)
# slice 0 is the low 9 bits of the word, slice 3 the high 9 bits
0 0200C0401 001 002 003 004
0 007FC01FF 1ff 000 1ff 000
0 FF803FE00 000 1ff 000 1ff
0 AAAAAAAAA 0aa 155 0aa 155
0 555555555 155 0aa 155 0aa
0 44D9C8B23 123 045 167 089
1 200C04010 010 020 030 040
2 101010100 100 080 040 020
3 61F841EF0 0f0 00f 1e1 0c3
1 8C39CB5A5 1a5 05a 0e7 118
2 B32671077 077 188 099 166
3 FE00FFC01 001 1fe 003 1fc
3 77AF95ADE 0de 0ad 0be 0ef
2 016F6F335 135 179 1bd 002
1 803FE00FF 0ff 100 0ff 100
0 1C71C71C7 1c7 038 1c7 038
1 600C01803 003 00c 030 0c0
3 0F7803DE0 1e0 01e 1e0 01e

// File: bench/rw_manager_di_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_di_tb;

	logic clock;
	logic rst;
	rw_manager_pkg::capture_beat_t cap;
	rw_manager_pkg::credit_ret_t cred;
	rw_manager_pkg::out_beat_t out;
	logic out_credit;

	// stimulus lines in file order and whether each one has been sent
	int line_grp [$];
	logic [`RW_DI_WORD_SIZE-1:0] line_word [$];
	bit line_sent [$];
	// expected beats are searched by group since only per-group order is defined
	rw_manager_pkg::out_beat_t exp_q [$];
	// sender view of free buffer words in each group
	int cap_credit [`RW_DI_NUM_GROUPS];
	// beats taken downstream whose slot has not been handed back yet
	int owed;
	int sent_cnt;
	int cycle;
	logic [31:0] lfsr;
	bit loaded;

	rw_manager_di_top u_rw_manager_di_top (
		.clock(clock),
		.rst(rst),
		.cap(cap),
		.cred(cred),
		.out(out),
		.out_credit(out_credit)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 hands out the bit it shifts in
	function automatic logic take_bit();
		logic b;
		b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], b};
		return b;
	endfunction

	task automatic load_stimulus();
		int fd;
		int code;
		int grp;
		logic [`RW_DI_WORD_SIZE-1:0] word;
		rw_manager_pkg::slice_t sl [4];
		rw_manager_pkg::out_beat_t eb;
		string text;
		fd = $fopen("bench/rw_manager_di_stim.txt", "r");
		if (fd == 0) begin
			stop_with_failure("could not open the stimulus file bench/rw_manager_di_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				code = $fgets(text, fd);
				// comment and blank lines do not parse and fall through
				code = $sscanf(text, "%h %h %h %h %h %h", grp, word,
					sl[0], sl[1], sl[2], sl[3]);
				if (code == 6) begin
					line_grp.push_back(grp);
					line_word.push_back(word);
					line_sent.push_back(1'b0);
					for (int i = 0; i < 4; i++) begin
						eb.valid = 1'b1;
						eb.group = rw_manager_pkg::group_t'(grp);
						eb.slice_idx = rw_manager_pkg::slice_idx_t'(i);
						eb.slice = sl[i];
						exp_q.push_back(eb);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// pick the earliest unsent line whose group holds a credit and has no older line
	// waiting so a full group never blocks the others
	function automatic int pick_line();
		bit [`RW_DI_NUM_GROUPS-1:0] held;
		held = '0;
		for (int i = 0; i < line_grp.size(); i++) begin
			if (!line_sent[i]) begin
				if (!held[line_grp[i]] && cap_credit[line_grp[i]] > 0) begin
					return i;
				end
				held[line_grp[i]] = 1'b1;
			end
		end
		return -1;
	endfunction

	task automatic check_beat(input rw_manager_pkg::out_beat_t got);
		int hit;
		rw_manager_pkg::out_beat_t exp;
		hit = -1;
		for (int i = exp_q.size() - 1; i >= 0; i--) begin
			if (exp_q[i].group == got.group) begin
				hit = i;
			end
		end
		if (hit < 0) begin
			stop_with_failure($sformatf("ERROR at %0t ns: beat for group %0d with nothing pending",
				$time, got.group));
		end else begin
			exp = exp_q[hit];
			exp_q.delete(hit);
			if (got !== exp) begin
				stop_with_failure($sformatf(
					"ERROR at %0t ns: group %0d expected slice %0d = %h, got slice %0d = %h",
					$time, exp.group, exp.slice_idx, exp.slice, got.slice_idx, got.slice));
			end
		end
	endtask

	task automatic check_cred(input rw_manager_pkg::credit_ret_t got);
		int g;
		g = int'(got.group);
		if (g >= `RW_DI_NUM_GROUPS || cap_credit[g] >= `RW_DI_BUF_DEPTH) begin
			stop_with_failure($sformatf("ERROR at %0t ns: capture credit for group %0d %s",
				$time, g, "returned with no word outstanding"));
		end else begin
			cap_credit[g]++;
		end
	endtask

	function automatic bit run_done();
		bit done;
		done = (sent_cnt == line_grp.size()) && (exp_q.size() == 0) && (owed == 0);
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			done = done && (cap_credit[g] == `RW_DI_BUF_DEPTH);
		end
		return done;
	endfunction

	// outputs are sampled on the falling edge and inputs driven just after the rising edge
	task automatic one_cycle();
		int pick;
		logic go;
		logic ret;
		@(negedge clock);
		if (out.valid) begin
			check_beat(out);
			owed++;
			if (owed > `RW_DI_OUT_CREDITS) begin
				stop_with_failure($sformatf("ERROR at %0t ns: %0d beats outstanding, limit %0d",
					$time, owed, `RW_DI_OUT_CREDITS));
			end
		end
		if (cred.valid) begin
			check_cred(cred);
		end
		@(posedge clock);
		#1;
		cycle++;
		cap = '0;
		go = take_bit();
		pick = pick_line();
		if (go && pick >= 0) begin
			cap.valid = 1'b1;
			cap.group = rw_manager_pkg::group_t'(line_grp[pick]);
			cap.word.raw = line_word[pick];
			line_sent[pick] = 1'b1;
			cap_credit[line_grp[pick]]--;
			sent_cnt++;
		end
		// downstream holds its slots for 24 of every 64 cycles and then flips a coin
		out_credit = 1'b0;
		ret = take_bit();
		if (owed > 0 && (cycle % 64) >= 24 && ret) begin
			out_credit = 1'b1;
			owed--;
		end
	endtask

	initial begin
		rst = 1'b1;
		cap = '0;
		out_credit = 1'b0;
		lfsr = 32'hbf561317;
		owed = 0;
		sent_cnt = 0;
		cycle = 0;
		loaded = 1'b0;
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			cap_credit[g] = `RW_DI_BUF_DEPTH;
		end
		load_stimulus();
		loaded = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;
		while (!run_done()) begin
			one_cycle();
		end
		// idle tail so a stray beat or credit is still caught
		repeat (20) one_cycle();
		if (!run_done()) begin
			stop_with_failure("traffic was still pending after the idle tail");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

	initial begin
		wait (loaded);
		repeat (200 * line_grp.size()) @(posedge clock);
		stop_with_failure($sformatf("watchdog expired after %0d clock cycles, the run timed out",
			200 * line_grp.size()));
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/rw_manager_pkg.sv
hdl/rw_manager_di_buffer.sv
hdl/rw_manager_di_buffer_wrap.sv
hdl/rw_manager_capture_dist.sv
hdl/rw_manager_readback.sv
hdl/rw_manager_di_top.sv
bench/rw_manager_di_assertions.sv
bench/rw_manager_di_tb.sv

// File: hdl/rw_manager_capture_dist.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_capture_dist (
	input wire logic clock,
	input wire logic rst,
	input rw_manager_pkg::capture_beat_t cap,
	input wire logic [`RW_DI_NUM_GROUPS-1:0] word_free,
	output rw_manager_pkg::buf_wr_t wr [`RW_DI_NUM_GROUPS],
	output logic [`RW_DI_NUM_GROUPS-1:0] word_added,
	output rw_manager_pkg::credit_ret_t cred
);

	// next free slot of each group buffer
	rw_manager_pkg::word_idx_t wr_ptr [`RW_DI_NUM_GROUPS];
	// group of the word being freed this cycle, valid when any bit is set
	rw_manager_pkg::group_t free_group;
	logic free_any;

	// decode the beat to its group, data and pointer fan out to every buffer
	always_comb begin
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			wr[g].wren = cap.valid && (cap.group == rw_manager_pkg::group_t'(g));
			wr[g].wraddress = wr_ptr[g];
			wr[g].data = cap.word;
			// the readback engine counts the word in the same cycle it is written
			word_added[g] = wr[g].wren;
		end
	end

	// write pointers advance once per accepted beat
	// the sender never overruns a group since it spends a credit per beat
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
				wr_ptr[g] <= '0;
			end
		end else begin
			for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
				if (wr[g].wren) begin
					wr_ptr[g] <= rw_manager_pkg::next_word(wr_ptr[g]);
				end
			end
		end
	end

	// at most one group frees a word per cycle, so a plain encoder is enough
	always_comb begin
		free_group = '0;
		free_any = 1'b0;
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			if (word_free[g]) begin
				free_group = rw_manager_pkg::group_t'(g);
				free_any = 1'b1;
			end
		end
	end

	// credit return lags the free pulse by one cycle
	always_ff @(posedge clock) begin
		cred.group <= free_group;
		if (rst) begin
			cred.valid <= 1'b0;
		end else begin
			cred.valid <= free_any;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rw_manager_config.svh
`ifndef RW_MANAGER_CONFIG_SVH
`define RW_MANAGER_CONFIG_SVH

// number of DQ groups, one data-in buffer wrapper per group
`define RW_DI_NUM_GROUPS 4
// width of one read slice as seen by the readback engine
`define RW_DI_READ_DATA_SIZE 9
// log2 of the number of slices packed into one captured word
`define RW_DI_RATIO_EXP 2
// log2 of the number of words each group buffer holds
`define RW_DI_BUF_DEPTH_EXP 2
// beat slots the downstream consumer grants after reset
`define RW_DI_OUT_CREDITS 4

// derived sizes, kept at least one bit wide so a zero exponent still builds
`define RW_DI_RATIO (1 << `RW_DI_RATIO_EXP)
`define RW_DI_WORD_SIZE (`RW_DI_READ_DATA_SIZE * `RW_DI_RATIO)
`define RW_DI_BUF_DEPTH (1 << `RW_DI_BUF_DEPTH_EXP)
`define RW_DI_GROUP_W ((`RW_DI_NUM_GROUPS > 1) ? $clog2(`RW_DI_NUM_GROUPS) : 1)
`define RW_DI_WORD_IDX_W ((`RW_DI_BUF_DEPTH_EXP > 0) ? `RW_DI_BUF_DEPTH_EXP : 1)
`define RW_DI_SLICE_IDX_W ((`RW_DI_RATIO_EXP > 0) ? `RW_DI_RATIO_EXP : 1)
// read address is the word index sitting above the slice index
`define RW_DI_RDADDR_W (`RW_DI_WORD_IDX_W + `RW_DI_RATIO_EXP)

`endif

// File: hdl/rw_manager_di_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_di_buffer (
	input wire logic clock,
	input rw_manager_pkg::buf_wr_t wr,
	input rw_manager_pkg::word_idx_t rd_word,
	input wire logic rden,
	output rw_manager_pkg::di_word_u q
);

	// one full captured word per entry, no reset on the array
	logic [`RW_DI_WORD_SIZE-1:0] mem [`RW_DI_BUF_DEPTH];

	// write side stores the whole word in one cycle
	always_ff @(posedge clock) begin
		if (wr.wren) begin
			mem[wr.wraddress] <= wr.data.raw;
		end
	end

	// registered read, q holds its value when rden is low
	// so the slice mux downstream sees a stable word
	always_ff @(posedge clock) begin
		if (rden) begin
			q.raw <= mem[rd_word];
		end
	end

	// the readback engine only reads words whose fill was counted a cycle
	// after the write, so the same entry is never written and read together

endmodule

`default_nettype wire

// File: hdl/rw_manager_di_buffer_wrap.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_di_buffer_wrap (
	input wire logic clock,
	input wire logic rst,
	input rw_manager_pkg::buf_wr_t wr,
	input rw_manager_pkg::buf_rd_t rd,
	output rw_manager_pkg::slice_rsp_t rsp
);

	rw_manager_pkg::di_word_u q;
	// slice field of the incoming request and its copy aligned with q
	rw_manager_pkg::slice_idx_t sel_d;
	rw_manager_pkg::slice_idx_t sel_q;
	logic rden_q;
	rw_manager_pkg::slice_t slice_mux;

	// upper address bits pick the word inside the buffer
	rw_manager_di_buffer u_di_buffer (
		.clock(clock),
		.wr(wr),
		.rd_word(rd.rdaddress[`RW_DI_RDADDR_W-1:`RW_DI_RATIO_EXP]),
		.rden(rd.rden),
		.q(q)
	);

	generate
		if (`RW_DI_RATIO_EXP > 0) begin : g_slice_mux
			// lower address bits choose one slice of the word
			assign sel_d = rd.rdaddress[`RW_DI_RATIO_EXP-1:0];
			assign slice_mux = q.slices[sel_q];
		end else begin : g_slice_pass
			// a word holds a single slice, so it passes straight through
			assign sel_d = '0;
			assign slice_mux = q.raw;
		end
	endgenerate

	// stage one tracks the buffer read, stage two registers the chosen slice
	// giving rsp two cycles after rden
	always_ff @(posedge clock) begin
		sel_q <= sel_d;
		rsp.slice <= slice_mux;
		if (rst) begin
			rden_q <= 1'b0;
			rsp.valid <= 1'b0;
		end else begin
			rden_q <= rd.rden;
			rsp.valid <= rden_q;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rw_manager_di_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_di_top (
	input wire logic clock,
	input wire logic rst,
	input rw_manager_pkg::capture_beat_t cap,
	output rw_manager_pkg::credit_ret_t cred,
	output rw_manager_pkg::out_beat_t out,
	input wire logic out_credit
);

	// per-group write commands from the distributor
	rw_manager_pkg::buf_wr_t wr [`RW_DI_NUM_GROUPS];
	// per-group read requests and slice responses
	rw_manager_pkg::buf_rd_t rd [`RW_DI_NUM_GROUPS];
	rw_manager_pkg::slice_rsp_t rsp [`RW_DI_NUM_GROUPS];
	logic [`RW_DI_NUM_GROUPS-1:0] word_added;
	logic [`RW_DI_NUM_GROUPS-1:0] word_free;

	rw_manager_capture_dist u_capture_dist (
		.clock(clock),
		.rst(rst),
		.cap(cap),
		.word_free(word_free),
		.wr(wr),
		.word_added(word_added),
		.cred(cred)
	);

	// one buffer wrapper for each DQ group
	generate
		for (genvar g = 0; g < `RW_DI_NUM_GROUPS; g++) begin : g_group
			rw_manager_di_buffer_wrap u_di_buffer_wrap (
				.clock(clock),
				.rst(rst),
				.wr(wr[g]),
				.rd(rd[g]),
				.rsp(rsp[g])
			);
		end
	endgenerate

	rw_manager_readback u_readback (
		.clock(clock),
		.rst(rst),
		.word_added(word_added),
		.out_credit(out_credit),
		.rsp(rsp),
		.rd(rd),
		.word_free(word_free),
		.out(out)
	);

endmodule

`default_nettype wire

// File: hdl/rw_manager_pkg.sv
`default_nettype none

`include "rw_manager_config.svh"

package rw_manager_pkg;

	typedef logic [`RW_DI_READ_DATA_SIZE-1:0] slice_t;
	typedef logic [`RW_DI_GROUP_W-1:0] group_t;
	typedef logic [`RW_DI_WORD_IDX_W-1:0] word_idx_t;
	typedef logic [`RW_DI_SLICE_IDX_W-1:0] slice_idx_t;
	typedef logic [`RW_DI_RDADDR_W-1:0] rdaddr_t;

	// the buffer stores the raw vector while the wrapper picks one slice out of it
	typedef union packed {
		logic [`RW_DI_WORD_SIZE-1:0] raw;
		slice_t [`RW_DI_RATIO-1:0] slices;
	} di_word_u;

	// one captured word, tagged with the DQ group it was sampled from
	typedef struct packed {
		logic valid;
		group_t group;
		di_word_u word;
	} capture_beat_t;

	// returns a single capture credit to the sender for the given group
	typedef struct packed {
		logic valid;
		group_t group;
	} credit_ret_t;

	typedef struct packed {
		logic wren;
		word_idx_t wraddress;
		di_word_u data;
	} buf_wr_t;

	typedef struct packed {
		logic rden;
		rdaddr_t rdaddress;
	} buf_rd_t;

	typedef struct packed {
		logic valid;
		slice_t slice;
	} slice_rsp_t;

	typedef struct packed {
		logic valid;
		group_t group;
		slice_idx_t slice_idx;
		slice_t slice;
	} out_beat_t;

	// circular step through the words of one group buffer
	function automatic word_idx_t next_word(input word_idx_t ptr);
		if (ptr == word_idx_t'(`RW_DI_BUF_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

endpackage

`default_nettype wire

// File: hdl/rw_manager_readback.sv
`timescale 1ns/1ps
`default_nettype none

`include "rw_manager_config.svh"

module rw_manager_readback (
	input wire logic clock,
	input wire logic rst,
	input wire logic [`RW_DI_NUM_GROUPS-1:0] word_added,
	input wire logic out_credit,
	input rw_manager_pkg::slice_rsp_t rsp [`RW_DI_NUM_GROUPS],
	output rw_manager_pkg::buf_rd_t rd [`RW_DI_NUM_GROUPS],
	output logic [`RW_DI_NUM_GROUPS-1:0] word_free,
	output rw_manager_pkg::out_beat_t out
);

	typedef logic [$clog2(`RW_DI_BUF_DEPTH + 1)-1:0] occ_t;
	typedef logic [$clog2(`RW_DI_OUT_CREDITS + 1)-1:0] credit_t;

	// words still holding at least one unread slice, per group
	occ_t occ [`RW_DI_NUM_GROUPS];
	rw_manager_pkg::word_idx_t rd_ptr [`RW_DI_NUM_GROUPS];
	rw_manager_pkg::slice_idx_t slice_cnt [`RW_DI_NUM_GROUPS];
	credit_t credits;
	// last group served, the search starts just after it
	rw_manager_pkg::group_t rr_last;
	rw_manager_pkg::group_t grant;
	logic grant_vld;
	logic issue;
	logic [`RW_DI_NUM_GROUPS-1:0] last_slice;
	// group and slice index ride along with the read, two stages to meet rsp
	rw_manager_pkg::group_t tag_grp [2];
	rw_manager_pkg::slice_idx_t tag_idx [2];
	logic rsp_vld;
	rw_manager_pkg::slice_t rsp_slice;

	// round-robin pick of the first non-empty group after rr_last
	always_comb begin
		int idx;
		grant_vld = 1'b0;
		grant = '0;
		for (int i = 1; i <= `RW_DI_NUM_GROUPS; i++) begin
			idx = (int'(rr_last) + i) % `RW_DI_NUM_GROUPS;
			if (!grant_vld && (occ[idx] != '0)) begin
				grant_vld = 1'b1;
				grant = rw_manager_pkg::group_t'(idx);
			end
		end
	end

	// a read goes out only with a downstream beat slot in hand
	assign issue = grant_vld && (credits != '0);

	always_comb begin
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			rd[g].rden = issue && (grant == rw_manager_pkg::group_t'(g));
			// word index shifted above the slice index
			rd[g].rdaddress = (rw_manager_pkg::rdaddr_t'(rd_ptr[g]) << `RW_DI_RATIO_EXP)
				| rw_manager_pkg::rdaddr_t'(slice_cnt[g]);
			last_slice[g] = rd[g].rden
				&& (slice_cnt[g] == rw_manager_pkg::slice_idx_t'(`RW_DI_RATIO - 1));
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
				occ[g] <= '0;
				rd_ptr[g] <= '0;
				slice_cnt[g] <= '0;
			end
			credits <= credit_t'(`RW_DI_OUT_CREDITS);
			rr_last <= '0;
			word_free <= '0;
		end else begin
			for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
				// the word leaves the count as soon as its last slice is requested
				occ[g] <= occ[g] + occ_t'(word_added[g]) - occ_t'(last_slice[g]);
				if (last_slice[g]) begin
					slice_cnt[g] <= '0;
					rd_ptr[g] <= rw_manager_pkg::next_word(rd_ptr[g]);
				end else if (rd[g].rden) begin
					slice_cnt[g] <= slice_cnt[g] + 1'b1;
				end
			end
			credits <= credits + credit_t'(out_credit) - credit_t'(issue);
			if (issue) begin
				rr_last <= grant;
			end
			// free pulse trails the last slice read by one cycle
			word_free <= last_slice;
		end
	end

	always_ff @(posedge clock) begin
		tag_grp[0] <= grant;
		tag_idx[0] <= slice_cnt[grant];
		tag_grp[1] <= tag_grp[0];
		tag_idx[1] <= tag_idx[0];
	end

	// only one wrapper answers per cycle, so OR-ing the responses is safe
	always_comb begin
		rsp_vld = 1'b0;
		rsp_slice = '0;
		for (int g = 0; g < `RW_DI_NUM_GROUPS; g++) begin
			if (rsp[g].valid) begin
				rsp_vld = 1'b1;
				rsp_slice = rsp_slice | rsp[g].slice;
			end
		end
	end

	// output beat lands three cycles after its read request
	always_ff @(posedge clock) begin
		out.group <= tag_grp[1];
		out.slice_idx <= tag_idx[1];
		out.slice <= rsp_slice;
		if (rst) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= rsp_vld;
		end
	end

endmodule

`default_nettype wire
